//--- design/rv_pkg.sv
package rv_pkg;

  // Major opcodes with standard RV32 encodings
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_ATOMIC = 7'b0101111
  } opcode_e;

  // Coded as {instr[25], instr[30], funct3}
  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLT  = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SRA  = 5'b01101,
    ALU_MUL  = 5'b10000
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ   = 3'b000,
    BR_NE   = 3'b001,
    BR_NONE = 3'b010,
    BR_LT   = 3'b100,
    BR_GE   = 3'b101,
    BR_LTU  = 3'b110,
    BR_GEU  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_BYTE   = 3'b000,
    MEM_HALF   = 3'b001,
    MEM_WORD   = 3'b010,
    MEM_BYTE_U = 3'b100,
    MEM_HALF_U = 3'b101
  } mem_len_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXECUTE,
    ST_MEMORY
  } core_state_e;

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] immediate;
    logic        alu_use_rs2;
    alu_op_e     alu_op;
    logic        reg_write;
    logic        mem_write;
    logic        mem_read;
    mem_len_e    mem_len;
    branch_e     branch_type;
  } decode_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
  } writeback_t;

endpackage

//--- design/decoder.sv
`timescale 1ns/1ns

module decoder (
  input  logic [31:0]     instruction,
  output rv_pkg::decode_t dec
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic            is_mem;
  logic            is_shift_imm;

  assign opcode = rv_pkg::opcode_e'(instruction[6:0]);
  assign funct3 = instruction[14:12];

  assign is_mem = (opcode == rv_pkg::OP_LOAD) || (opcode == rv_pkg::OP_STORE) ||
                  (opcode == rv_pkg::OP_ATOMIC);
  assign is_shift_imm = (opcode == rv_pkg::OP_IMM) &&
                        ((funct3 == 3'b001) || (funct3 == 3'b101));

  always_comb begin
    dec.rs1 = instruction[19:15];
    dec.rs2 = instruction[24:20];
    dec.rd  = instruction[11:7];

    // Immediate format by instruction class
    if (is_shift_imm) begin
      dec.immediate = {27'b0, instruction[24:20]};
    end else if (opcode == rv_pkg::OP_STORE) begin
      dec.immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    end else if (opcode == rv_pkg::OP_BRANCH) begin
      dec.immediate = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
    end else if (opcode == rv_pkg::OP_ATOMIC) begin
      dec.immediate = 32'b0;
    end else begin
      dec.immediate = {{20{instruction[31]}}, instruction[31:20]};
    end

    // Address arithmetic for memory classes
    if (is_mem) begin
      dec.alu_op = rv_pkg::ALU_ADD;
    end else if (opcode == rv_pkg::OP_IMM && !is_shift_imm) begin
      dec.alu_op = rv_pkg::alu_op_e'({2'b00, funct3});
    end else begin
      dec.alu_op = rv_pkg::alu_op_e'({instruction[25], instruction[30], funct3});
    end

    dec.alu_use_rs2 = (opcode == rv_pkg::OP_REG);
    dec.reg_write   = (opcode == rv_pkg::OP_LOAD) || (opcode == rv_pkg::OP_REG) ||
                      (opcode == rv_pkg::OP_IMM) || (opcode == rv_pkg::OP_ATOMIC);
    dec.mem_read    = (opcode == rv_pkg::OP_LOAD) || (opcode == rv_pkg::OP_ATOMIC);
    dec.mem_write   = (opcode == rv_pkg::OP_STORE) || (opcode == rv_pkg::OP_ATOMIC);
    dec.mem_len     = rv_pkg::mem_len_e'(funct3);

    if (opcode == rv_pkg::OP_BRANCH) begin
      dec.branch_type = rv_pkg::branch_e'(funct3);
    end else begin
      dec.branch_type = rv_pkg::BR_NONE;
    end
  end

endmodule

//--- design/fetch_control.sv
`timescale 1ns/1ns

module fetch_control #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic [31:0]     instr,
  input  rv_pkg::decode_t dec,
  input  logic [31:0]     rs1_value,
  input  logic [31:0]     rs2_value,
  output logic [31:0]     pc,
  output logic            fetch,
  output logic [31:0]     instruction,
  output logic            exec_cycle,
  output logic            mem_cycle
);

  rv_pkg::core_state_e state;
  logic                taken;
  logic [31:0]         next_pc;

  always_comb begin
    case (dec.branch_type)
      rv_pkg::BR_EQ:  taken = (rs1_value == rs2_value);
      rv_pkg::BR_NE:  taken = (rs1_value != rs2_value);
      rv_pkg::BR_LT:  taken = ($signed(rs1_value) < $signed(rs2_value));
      rv_pkg::BR_GE:  taken = ($signed(rs1_value) >= $signed(rs2_value));
      rv_pkg::BR_LTU: taken = (rs1_value < rs2_value);
      rv_pkg::BR_GEU: taken = (rs1_value >= rs2_value);
      default:        taken = 1'b0;
    endcase
  end

  // Non-branches see BR_NONE and fall through to pc + 4
  assign next_pc = taken ? pc + dec.immediate : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_pkg::ST_FETCH;
      pc    <= RESET_PC;
    end else begin
      case (state)
        rv_pkg::ST_FETCH: state <= rv_pkg::ST_EXECUTE;
        rv_pkg::ST_EXECUTE: begin
          if (dec.mem_read) begin
            state <= rv_pkg::ST_MEMORY;
          end else begin
            state <= rv_pkg::ST_FETCH;
            pc    <= next_pc;
          end
        end
        rv_pkg::ST_MEMORY: begin
          state <= rv_pkg::ST_FETCH;
          pc    <= next_pc;
        end
        default: state <= rv_pkg::ST_FETCH;
      endcase
    end
  end

  // Instruction word is valid at the end of the fetch cycle
  always_ff @(posedge clk) begin
    if (state == rv_pkg::ST_FETCH) begin
      instruction <= instr;
    end
  end

  assign fetch      = (state == rv_pkg::ST_FETCH);
  assign exec_cycle = (state == rv_pkg::ST_EXECUTE);
  assign mem_cycle  = (state == rv_pkg::ST_MEMORY);

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic               clk,
  input  logic               reset,
  input  logic [4:0]         rs1,
  input  logic [4:0]         rs2,
  output logic [31:0]        rs1_value,
  output logic [31:0]        rs2_value,
  input  logic               wb_valid,
  input  rv_pkg::writeback_t wb
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'b0;
      end
    end else if (wb_valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_value = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
  assign rs2_value = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu (
  input  rv_pkg::alu_op_e op,
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  output logic [31:0]     result
);

  logic [4:0]  shamt;
  logic [31:0] product;

  assign shamt   = b[4:0];
  // Only the low word is kept
  assign product = a * b;

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB:  result = a - b;
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU: result = {31'b0, a < b};
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_AND:  result = a & b;
      rv_pkg::ALU_MUL:  result = product;
      default:          result = 32'b0;
    endcase
  end

endmodule

//--- design/memory_stage.sv
`timescale 1ns/1ns

module memory_stage #(
  parameter int DMEM_WORDS = 256
) (
  input  logic               clk,
  input  logic               reset,
  input  rv_pkg::decode_t    dec,
  input  logic               exec_cycle,
  input  logic               mem_cycle,
  input  logic [31:0]        alu_result,
  input  logic [31:0]        rs2_value,
  output logic               wb_valid,
  output rv_pkg::writeback_t wb
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic [31:0]   dmem [DMEM_WORDS];
  logic [AW-1:0] word_addr;
  logic [1:0]    offset;
  logic [3:0]    byte_en;
  logic [31:0]   store_data;
  logic [31:0]   read_word;
  logic [31:0]   shifted;
  logic [31:0]   load_data;
  logic          is_store;
  logic          is_swap;

  assign word_addr = alu_result[AW+1:2];
  assign offset    = alu_result[1:0];
  assign is_store  = dec.mem_write && !dec.mem_read;
  assign is_swap   = dec.mem_write && dec.mem_read;

  // Lane enables and replicated store data
  always_comb begin
    case (dec.mem_len)
      rv_pkg::MEM_BYTE: begin
        byte_en    = 4'b0001 << offset;
        store_data = {4{rs2_value[7:0]}};
      end
      rv_pkg::MEM_HALF: begin
        byte_en    = offset[1] ? 4'b1100 : 4'b0011;
        store_data = {2{rs2_value[15:0]}};
      end
      default: begin
        byte_en    = 4'b1111;
        store_data = rs2_value;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (exec_cycle && is_store) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) begin
          dmem[word_addr][8*i +: 8] <= store_data[8*i +: 8];
        end
      end
    end else if (mem_cycle && is_swap) begin
      dmem[word_addr] <= rs2_value;
    end
  end

  // Synchronous read at the end of EXECUTE
  always_ff @(posedge clk) begin
    if (reset) begin
      read_word <= 32'b0;
    end else if (exec_cycle && dec.mem_read) begin
      read_word <= dmem[word_addr];
    end
  end

  assign shifted = read_word >> {offset, 3'b000};

  always_comb begin
    case (dec.mem_len)
      rv_pkg::MEM_BYTE:   load_data = {{24{shifted[7]}}, shifted[7:0]};
      rv_pkg::MEM_HALF:   load_data = {{16{shifted[15]}}, shifted[15:0]};
      rv_pkg::MEM_BYTE_U: load_data = {24'b0, shifted[7:0]};
      rv_pkg::MEM_HALF_U: load_data = {16'b0, shifted[15:0]};
      default:            load_data = read_word;
    endcase
  end

  // Loads and swaps retire in MEMORY, everything else in EXECUTE
  assign wb_valid = dec.reg_write && (dec.rd != 5'd0) &&
                    (dec.mem_read ? mem_cycle : exec_cycle);
  assign wb.rd    = dec.rd;
  assign wb.data  = dec.mem_read ? load_data : alu_result;

endmodule

//--- design/rv32_core.sv
`timescale 1ns/1ns

module rv32_core #(
  parameter logic [31:0] RESET_PC   = 32'h0,
  parameter int          DMEM_WORDS = 256
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [31:0]        instr,
  output logic [31:0]        pc,
  output logic               fetch,
  output logic               wb_valid,
  output rv_pkg::writeback_t wb
);

  rv_pkg::decode_t dec;
  logic [31:0]     instruction;
  logic [31:0]     rs1_value;
  logic [31:0]     rs2_value;
  logic [31:0]     alu_b;
  logic [31:0]     alu_result;
  logic            exec_cycle;
  logic            mem_cycle;

  fetch_control #(
    .RESET_PC(RESET_PC)
  ) u_fetch_control (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .dec        (dec),
    .rs1_value  (rs1_value),
    .rs2_value  (rs2_value),
    .pc         (pc),
    .fetch      (fetch),
    .instruction(instruction),
    .exec_cycle (exec_cycle),
    .mem_cycle  (mem_cycle)
  );

  decoder u_decoder (
    .instruction(instruction),
    .dec        (dec)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_value(rs1_value),
    .rs2_value(rs2_value),
    .wb_valid (wb_valid),
    .wb       (wb)
  );

  // Second operand select
  assign alu_b = dec.alu_use_rs2 ? rs2_value : dec.immediate;

  alu u_alu (
    .op    (dec.alu_op),
    .a     (rs1_value),
    .b     (alu_b),
    .result(alu_result)
  );

  memory_stage #(
    .DMEM_WORDS(DMEM_WORDS)
  ) u_memory_stage (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .exec_cycle(exec_cycle),
    .mem_cycle (mem_cycle),
    .alu_result(alu_result),
    .rs2_value (rs2_value),
    .wb_valid  (wb_valid),
    .wb        (wb)
  );

endmodule

//--- tb/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

//--- tb/core_assertions.sv
`timescale 1ns/1ns

module core_assertions (
  input logic               clk,
  input logic               reset,
  input logic [31:0]        pc,
  input logic               fetch,
  input logic               wb_valid,
  input rv_pkg::writeback_t wb
);

  // Branch offsets in the programs are multiples of four
  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc %h is not word aligned", pc);

  wb_rd_nonzero: assert property (
    @(posedge clk) disable iff (reset) wb_valid |-> wb.rd != 5'd0
  ) else $error("write-back pulse targets x0");

  // First cycle after reset release is still a fetch
  single_fetch: assert property (
    @(posedge clk) reset || $past(reset) || !(fetch && $past(fetch))
  ) else $error("fetch high in two consecutive cycles");

endmodule

bind rv32_core core_assertions u_core_assertions (
  .clk     (clk),
  .reset   (reset),
  .pc      (pc),
  .fetch   (fetch),
  .wb_valid(wb_valid),
  .wb      (wb)
);

//--- tb/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  localparam int RESET_CYCLES = 16;
  localparam int CLK_PERIOD   = 20;
  // BEQ x0, x0, 0 spins on its own address
  localparam logic [31:0] HALT = 32'h0000_0063;
  localparam logic [2:0] IMM_FUNCT3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1,
                                            3'd5, 3'd5};
  localparam logic [2:0] REG_FUNCT3 [11] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5,
                                             3'd5, 3'd6, 3'd7, 3'd0};
  localparam logic [6:0] REG_FUNCT7 [11] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00,
                                             7'h00, 7'h20, 7'h00, 7'h00, 7'h01};
  localparam logic [2:0] BRANCH_FUNCT3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  logic               clk;
  logic               reset;
  logic [31:0]        instr;
  logic [31:0]        pc;
  logic               fetch;
  logic               wb_valid;
  rv_pkg::writeback_t wb;

  logic [31:0]        imem [256];
  int                 prog_len;
  rv_pkg::writeback_t expected [$];
  int                 errors;
  longint             deadline;

  clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock_gen (.clk(clk));

  rv32_core #(
    .RESET_PC  (32'h0),
    .DMEM_WORDS(256)
  ) u_rv32_core (
    .clk     (clk),
    .reset   (reset),
    .instr   (instr),
    .pc      (pc),
    .fetch   (fetch),
    .wb_valid(wb_valid),
    .wb      (wb)
  );

  // Instruction memory answers within the fetch cycle
  always @(posedge clk) begin
    #2;
    if (fetch) begin
      instr = imem[pc[9:2]];
    end
  end

  task automatic abort_run();
    errors++;
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_wb(input rv_pkg::writeback_t exp);
    if (wb !== exp) begin
      $display("error wb: expected rd %h data %h, got rd %h data %h",
               exp.rd, exp.data, wb.rd, wb.data);
      abort_run();
    end
  endtask

  task automatic check_pc(input logic [31:0] exp);
    if (pc !== exp) begin
      $display("error pc: expected %h, got %h", exp, pc);
      abort_run();
    end
  endtask

  always @(negedge clk) begin
    if (reset === 1'b0 && wb_valid === 1'b1) begin
      if (expected.size() == 0) begin
        $display("Unexpected write-back to x%0d with no instruction expecting one", wb.rd);
        abort_run();
      end else begin
        check_wb(expected.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if ($time > deadline) begin
      $display("Timeout: the core did not reach the end of its program in time");
      abort_run();
    end
  end

  function automatic logic [31:0] i_format(logic [11:0] imm, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_format(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_format(logic [11:0] imm, logic [4:0] rs2,
                                           logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_format(logic [12:0] imm, logic [4:0] rs2,
                                           logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic expect_wb(input logic [4:0] rd, input logic [31:0] data);
    rv_pkg::writeback_t item;
    item.rd   = rd;
    item.data = data;
    if (rd != 5'd0) begin
      expected.push_back(item);
    end
  endtask

  // Builds any 32-bit value from 11, 11 and 10 bit chunks
  task automatic load_value(input logic [4:0] rd, input logic [31:0] v);
    emit(i_format({1'b0, v[31:21]}, 5'd0, 3'b000, rd, rv_pkg::OP_IMM));
    expect_wb(rd, {21'b0, v[31:21]});
    emit(i_format(12'd11, rd, 3'b001, rd, rv_pkg::OP_IMM));
    expect_wb(rd, {10'b0, v[31:21], 11'b0});
    emit(i_format({1'b0, v[20:10]}, rd, 3'b110, rd, rv_pkg::OP_IMM));
    expect_wb(rd, {10'b0, v[31:10]});
    emit(i_format(12'd10, rd, 3'b001, rd, rv_pkg::OP_IMM));
    expect_wb(rd, {v[31:10], 10'b0});
    emit(i_format({2'b0, v[9:0]}, rd, 3'b110, rd, rv_pkg::OP_IMM));
    expect_wb(rd, v);
  endtask

  task automatic begin_program();
    @(posedge clk);
    #2;
    reset = 1'b1;
    prog_len = 0;
    expected.delete();
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0;
    end
  endtask

  task automatic start_program();
    deadline += longint'((prog_len * 3 + RESET_CYCLES + 1) * CLK_PERIOD);
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  task automatic wait_fetch(output logic [31:0] fetch_pc);
    do begin
      @(negedge clk);
    end while (fetch !== 1'b1);
    fetch_pc = pc;
  endtask

  task automatic check_done();
    if (expected.size() != 0) begin
      $display("%0d expected write-backs never appeared", expected.size());
      abort_run();
    end
  endtask

  task automatic run_to_halt();
    logic [31:0] halt_pc;
    logic [31:0] seen;
    halt_pc = 32'(prog_len * 4);
    emit(HALT);
    start_program();
    do begin
      wait_fetch(seen);
    end while (seen != halt_pc);
    check_done();
  endtask

  task automatic imm_alu_ops();
    logic [31:0] a;
    logic [11:0] imm;
    logic [31:0] simm;
    logic [31:0] exp;
    a = $urandom();
    begin_program();
    load_value(5'd1, a);
    for (int k = 0; k < 9; k++) begin
      imm = 12'($urandom());
      // Shifts keep only funct7 and the shamt in bits 24 to 20
      if (k >= 6) begin
        imm = {(k == 8) ? 7'b0100000 : 7'b0000000, imm[4:0]};
      end
      simm = {{20{imm[11]}}, imm};
      case (k)
        0: exp = a + simm;
        1: exp = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
        2: exp = (a < simm) ? 32'd1 : 32'd0;
        3: exp = a ^ simm;
        4: exp = a | simm;
        5: exp = a & simm;
        6: exp = a << imm[4:0];
        7: exp = a >> imm[4:0];
        default: exp = $unsigned($signed(a) >>> imm[4:0]);
      endcase
      emit(i_format(imm, 5'd1, IMM_FUNCT3[k], 5'(k + 3), rv_pkg::OP_IMM));
      expect_wb(5'(k + 3), exp);
    end
    run_to_halt();
  endtask

  task automatic reg_alu_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    a = $urandom();
    b = $urandom();
    begin_program();
    load_value(5'd1, a);
    load_value(5'd2, b);
    for (int k = 0; k < 11; k++) begin
      case (k)
        0: exp = a + b;
        1: exp = a - b;
        2: exp = a << b[4:0];
        3: exp = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        4: exp = (a < b) ? 32'd1 : 32'd0;
        5: exp = a ^ b;
        6: exp = a >> b[4:0];
        7: exp = $unsigned($signed(a) >>> b[4:0]);
        8: exp = a | b;
        9: exp = a & b;
        default: exp = a * b;
      endcase
      emit(r_format(REG_FUNCT7[k], 5'd2, 5'd1, REG_FUNCT3[k], 5'(k + 3), rv_pkg::OP_REG));
      expect_wb(5'(k + 3), exp);
    end
    run_to_halt();
  endtask

  task automatic load_store_lanes();
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] word;
    d = $urandom();
    e = $urandom();
    begin_program();
    load_value(5'd1, 32'h100);
    load_value(5'd2, d);
    load_value(5'd4, e);
    emit(s_format(12'd0, 5'd2, 5'd1, 3'b010));
    emit(s_format(12'd1, 5'd4, 5'd1, 3'b000));
    emit(s_format(12'd2, 5'd4, 5'd1, 3'b001));
    emit(s_format(12'd3, 5'd2, 5'd1, 3'b000));
    word = d;
    word[15:8] = e[7:0];
    word[31:16] = e[15:0];
    word[31:24] = d[7:0];
    for (int o = 0; o < 4; o++) begin
      emit(i_format(12'(o), 5'd1, 3'b000, 5'(5 + o), rv_pkg::OP_LOAD));
      expect_wb(5'(5 + o), {{24{word[8*o+7]}}, word[8*o +: 8]});
      emit(i_format(12'(o), 5'd1, 3'b100, 5'(9 + o), rv_pkg::OP_LOAD));
      expect_wb(5'(9 + o), {24'b0, word[8*o +: 8]});
    end
    for (int h = 0; h < 2; h++) begin
      emit(i_format(12'(2 * h), 5'd1, 3'b001, 5'(13 + h), rv_pkg::OP_LOAD));
      expect_wb(5'(13 + h), {{16{word[16*h+15]}}, word[16*h +: 16]});
      emit(i_format(12'(2 * h), 5'd1, 3'b101, 5'(15 + h), rv_pkg::OP_LOAD));
      expect_wb(5'(15 + h), {16'b0, word[16*h +: 16]});
    end
    emit(i_format(12'd0, 5'd1, 3'b010, 5'd17, rv_pkg::OP_LOAD));
    expect_wb(5'd17, word);
    run_to_halt();
  endtask

  task automatic branch_kinds();
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] seen;
    logic        taken;
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 3; p++) begin
        for (int back = 0; back < 2; back++) begin
          r = $urandom();
          s = $urandom();
          a = r;
          b = r;
          if (p == 1) begin
            a = r | 32'h8000_0000;
            b = s & 32'h7fff_ffff;
          end else if (p == 2) begin
            a = r & 32'h7fff_ffff;
            b = s | 32'h8000_0000;
          end
          case (BRANCH_FUNCT3[k])
            3'd0: taken = (a == b);
            3'd1: taken = (a != b);
            3'd4: taken = ($signed(a) < $signed(b));
            3'd5: taken = ($signed(a) >= $signed(b));
            3'd6: taken = (a < b);
            default: taken = (a >= b);
          endcase
          begin_program();
          load_value(5'd1, a);
          load_value(5'd2, b);
          // Layout from 40 is a jump to 48, a loop, the branch under test and two loops
          emit(b_format(13'd8, 5'd0, 5'd0, 3'b000));
          emit(HALT);
          emit(b_format((back == 1) ? 13'h1ffc : 13'd8, 5'd2, 5'd1, BRANCH_FUNCT3[k]));
          emit(HALT);
          emit(HALT);
          start_program();
          do begin
            wait_fetch(seen);
          end while (seen != 32'd48);
          wait_fetch(seen);
          check_pc(taken ? ((back == 1) ? 32'd44 : 32'd56) : 32'd52);
          check_done();
        end
      end
    end
  endtask

  task automatic atomic_swap();
    logic [31:0] old_word;
    logic [31:0] new_word;
    old_word = $urandom();
    new_word = $urandom();
    begin_program();
    load_value(5'd1, 32'h200);
    load_value(5'd2, old_word);
    load_value(5'd3, new_word);
    emit(s_format(12'd0, 5'd2, 5'd1, 3'b010));
    emit(r_format(7'b0000100, 5'd3, 5'd1, 3'b010, 5'd4, rv_pkg::OP_ATOMIC));
    expect_wb(5'd4, old_word);
    emit(i_format(12'd0, 5'd1, 3'b010, 5'd5, rv_pkg::OP_LOAD));
    expect_wb(5'd5, new_word);
    run_to_halt();
  endtask

  task automatic zero_register();
    logic [31:0] v;
    v = $urandom();
    begin_program();
    emit(i_format(12'h5a5, 5'd0, 3'b000, 5'd0, rv_pkg::OP_IMM));
    load_value(5'd1, v);
    emit(r_format(7'h00, 5'd1, 5'd1, 3'b000, 5'd0, rv_pkg::OP_REG));
    emit(r_format(7'h00, 5'd0, 5'd1, 3'b000, 5'd2, rv_pkg::OP_REG));
    expect_wb(5'd2, v);
    emit(i_format(12'h123, 5'd0, 3'b110, 5'd3, rv_pkg::OP_IMM));
    expect_wb(5'd3, 32'h123);
    run_to_halt();
  endtask

  initial begin
    errors = 0;
    reset = 1'b1;
    instr = 32'h0;
    prog_len = 0;
    deadline = longint'((RESET_CYCLES + 100) * CLK_PERIOD);
    void'($urandom(32'h7c7e));
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0;
    end
    imm_alu_ops();
    reg_alu_ops();
    load_store_lanes();
    branch_kinds();
    atomic_swap();
    zero_register();
    if (errors == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

//--- flist.f
design/rv_pkg.sv
design/decoder.sv
design/fetch_control.sv
design/reg_file.sv
design/alu.sv
design/memory_stage.sv
design/rv32_core.sv
tb/clock_gen.sv
tb/core_assertions.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
